// File: Makefile
# Verilator build and run for the ALU execute stage

VERILATOR ?= verilator
TOP       ?= exu_alu_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test passed

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/exu_alu.sv
////////////////////////////////////////
// ALU execute stage top level
// Group decode, operand gating, unit
// instances and the commit stage
////////////////////////////////////////

`timescale 1ns/1ps

module exu_alu (
  input  logic                   clk,
  input  logic                   i_rst,
  // Dispatch
  input  logic                   i_valid,
  output logic                   o_ready,
  input  exu_alu_pkg::xlen_t     i_rs1,
  input  exu_alu_pkg::xlen_t     i_rs2,
  input  exu_alu_pkg::xlen_t     i_imm,
  input  exu_alu_pkg::dec_info_t i_info,
  input  exu_alu_pkg::pc_t       i_pc,
  input  exu_alu_pkg::rfidx_t    i_rdidx,
  input  logic                   i_rdwen,
  // Commit
  output logic                   o_cmt_valid,
  input  logic                   i_cmt_ready,
  output exu_alu_pkg::cmt_t      o_cmt,
  // Classical write-back
  output logic                   o_cwbck_valid,
  input  logic                   i_cwbck_ready,
  output exu_alu_pkg::wbck_t     o_cwbck,
  // Quantum-classical write-back
  output logic                   o_qcwbck_valid,
  input  logic                   i_qcwbck_ready,
  output exu_alu_pkg::wbck_t     o_qcwbck
);
  import exu_alu_pkg::*;

  logic      bjp_op;
  logic      alu_op;

  xlen_t     alu_rs1;
  xlen_t     alu_rs2;
  xlen_t     alu_imm;
  dec_info_t alu_info;
  xlen_t     bjp_rs1;
  xlen_t     bjp_rs2;
  dec_info_t bjp_info;

  alu_req_t  alu_req;
  alu_req_t  bjp_req;
  xlen_t     dp_res;
  logic      dp_cmp_res;
  xlen_t     alu_wdata;
  logic      bjp_rslv;
  logic      bjp_prdt;

  cmt_t      cmt_in;
  wbck_t     wbck_in;

  ////////////////////////////////////////
  // Group decode and operand gating
  ////////////////////////////////////////
  assign bjp_op = i_info.grp_bjp;
  assign alu_op = ~bjp_op;

  // Idle unit sees all zeros
  assign alu_rs1  = alu_op ? i_rs1  : '0;
  assign alu_rs2  = alu_op ? i_rs2  : '0;
  assign alu_imm  = alu_op ? i_imm  : '0;
  assign alu_info = alu_op ? i_info : '0;
  assign bjp_rs1  = bjp_op ? i_rs1  : '0;
  assign bjp_rs2  = bjp_op ? i_rs2  : '0;
  assign bjp_info = bjp_op ? i_info : '0;

  exu_alu_rglr u_rglr (
    .i_rs1   (alu_rs1),
    .i_rs2   (alu_rs2),
    .i_imm   (alu_imm),
    .i_info  (alu_info),
    .i_res   (dp_res),
    .o_req   (alu_req),
    .o_wdata (alu_wdata)
  );

  exu_alu_bjp u_bjp (
    .i_rs1     (bjp_rs1),
    .i_rs2     (bjp_rs2),
    .i_info    (bjp_info),
    .i_cmp_res (dp_cmp_res),
    .o_req     (bjp_req),
    .o_rslv    (bjp_rslv),
    .o_prdt    (bjp_prdt)
  );

  exu_alu_dpath u_dpath (
    .i_alu_req (alu_req),
    .i_bjp_req (bjp_req),
    .i_bjp_sel (bjp_op),
    .i_cmp_eq  (bjp_info.cmp_eq),
    .i_cmp_ne  (bjp_info.cmp_ne),
    .i_cmp_lt  (bjp_info.cmp_lt),
    .i_cmp_gt  (bjp_info.cmp_gt),
    .o_res     (dp_res),
    .o_cmp_res (dp_cmp_res)
  );

  ////////////////////////////////////////
  // Result pick for commit
  ////////////////////////////////////////
  assign cmt_in.pc    = i_pc;
  assign cmt_in.imm   = i_imm;
  assign cmt_in.bjp   = bjp_op;
  assign cmt_in.prdt  = bjp_op & bjp_prdt;
  assign cmt_in.rslv  = bjp_op & bjp_rslv;

  assign wbck_in.data  = alu_op ? alu_wdata : '0;
  assign wbck_in.rdidx = i_rdidx;

  exu_alu_commit u_commit (
    .clk            (clk),
    .i_rst          (i_rst),
    .i_valid        (i_valid),
    .i_cmt          (cmt_in),
    .i_wbck         (wbck_in),
    .i_rdwen        (alu_op & i_rdwen),  // Branches never write back
    .i_cmt_ready    (i_cmt_ready),
    .i_cwbck_ready  (i_cwbck_ready),
    .i_qcwbck_ready (i_qcwbck_ready),
    .o_ready        (o_ready),
    .o_cmt_valid    (o_cmt_valid),
    .o_cmt          (o_cmt),
    .o_cwbck_valid  (o_cwbck_valid),
    .o_cwbck        (o_cwbck),
    .o_qcwbck_valid (o_qcwbck_valid),
    .o_qcwbck       (o_qcwbck)
  );

endmodule

// File: hdl/exu_alu_bjp.sv
////////////////////////////////////////
// Branch-compare unit
// Compare request and resolved outcome
////////////////////////////////////////

`timescale 1ns/1ps

module exu_alu_bjp (
  input  exu_alu_pkg::xlen_t     i_rs1,
  input  exu_alu_pkg::xlen_t     i_rs2,
  input  exu_alu_pkg::dec_info_t i_info,
  input  logic                   i_cmp_res,
  output exu_alu_pkg::alu_req_t  o_req,
  output logic                   o_rslv,
  output logic                   o_prdt
);
  import exu_alu_pkg::*;

  logic  cmp_any;
  xlen_t rs2_inv;

  assign cmp_any = i_info.cmp_eq | i_info.cmp_ne | i_info.cmp_lt | i_info.cmp_gt;

  assign rs2_inv = ~i_rs2;

  ////////////////////////////////////////
  // rs1 - rs2 on the shared adder
  ////////////////////////////////////////
  assign o_req.op1     = i_rs1;
  assign o_req.op2     = cmp_any ? rs2_inv : '0;
  assign o_req.cin     = cmp_any;
  assign o_req.sel_add = cmp_any;
  assign o_req.sel_xor = 1'b0;
  assign o_req.sel_or  = 1'b0;
  assign o_req.sel_and = 1'b0;

  // Outcome only counts with a compare selected
  assign o_rslv = cmp_any & i_cmp_res;
  assign o_prdt = cmp_any & i_info.bprdt;  // Echo of the prediction

endmodule

// File: hdl/exu_alu_commit.sv
////////////////////////////////////////
// One-entry commit stage
// Result register, write-back routing
// and coupled commit handshake
////////////////////////////////////////

`timescale 1ns/1ps

module exu_alu_commit (
  input  logic               clk,
  input  logic               i_rst,
  input  logic               i_valid,
  input  exu_alu_pkg::cmt_t  i_cmt,
  input  exu_alu_pkg::wbck_t i_wbck,
  input  logic               i_rdwen,
  input  logic               i_cmt_ready,
  input  logic               i_cwbck_ready,
  input  logic               i_qcwbck_ready,
  output logic               o_ready,
  output logic               o_cmt_valid,
  output exu_alu_pkg::cmt_t  o_cmt,
  output logic               o_cwbck_valid,
  output exu_alu_pkg::wbck_t o_cwbck,
  output logic               o_qcwbck_valid,
  output exu_alu_pkg::wbck_t o_qcwbck
);
  import exu_alu_pkg::*;

  logic  vld_q;
  logic  rdwen_q;
  cmt_t  cmt_q;
  wbck_t wbck_q;

  logic  qc_sel;
  logic  need_cwbck;
  logic  need_qcwbck;
  logic  wbck_rdy;
  logic  drain;
  logic  load;

  ////////////////////////////////////////
  // Write-back port selection
  ////////////////////////////////////////
  assign qc_sel      = wbck_q.rdidx[RFIDX_WIDTH-1];
  assign need_cwbck  = rdwen_q & ~qc_sel;
  assign need_qcwbck = rdwen_q & qc_sel;

  // Ready of the write-back port this entry needs
  always_comb begin
    if (need_cwbck) begin
      wbck_rdy = i_cwbck_ready;
    end else if (need_qcwbck) begin
      wbck_rdy = i_qcwbck_ready;
    end else begin
      wbck_rdy = 1'b1;             // Nothing to write back
    end
  end

  assign drain   = vld_q & i_cmt_ready & wbck_rdy;
  assign o_ready = ~vld_q | drain;  // Back-to-back when draining
  assign load    = i_valid & o_ready;

  ////////////////////////////////////////
  // Entry register
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (i_rst) begin
      vld_q   <= 1'b0;
      rdwen_q <= 1'b0;
    end else if (load) begin
      vld_q   <= 1'b1;
      rdwen_q <= i_rdwen;
    end else if (drain) begin
      vld_q   <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      cmt_q  <= i_cmt;
      wbck_q <= i_wbck;
    end
  end

  ////////////////////////////////////////
  // Output handshakes
  ////////////////////////////////////////
  // Commit and write-back only ever move together
  assign o_cmt_valid    = vld_q & wbck_rdy;
  assign o_cwbck_valid  = vld_q & need_cwbck & i_cmt_ready;
  assign o_qcwbck_valid = vld_q & need_qcwbck & i_cmt_ready;

  assign o_cmt    = cmt_q;
  assign o_cwbck  = need_cwbck  ? wbck_q : '0;  // Quiet on unused port
  assign o_qcwbck = need_qcwbck ? wbck_q : '0;

endmodule

// File: hdl/exu_alu_dpath.sv
////////////////////////////////////////
// Shared ALU datapath
// One adder, logic ops, compare flags
////////////////////////////////////////

`timescale 1ns/1ps

module exu_alu_dpath (
  input  exu_alu_pkg::alu_req_t i_alu_req,
  input  exu_alu_pkg::alu_req_t i_bjp_req,
  input  logic                  i_bjp_sel,
  input  logic                  i_cmp_eq,
  input  logic                  i_cmp_ne,
  input  logic                  i_cmp_lt,
  input  logic                  i_cmp_gt,
  output exu_alu_pkg::xlen_t    o_res,
  output logic                  o_cmp_res
);
  import exu_alu_pkg::*;

  alu_req_t req;
  xlen_t    sum;
  xlen_t    res_xor;
  xlen_t    res_or;
  xlen_t    res_and;
  logic     ovf;
  logic     flag_eq;
  logic     flag_lt;
  logic     flag_gt;

  // Requester mux
  assign req = i_bjp_sel ? i_bjp_req : i_alu_req;

  ////////////////////////////////////////
  // Adder and logic operators
  ////////////////////////////////////////
  assign sum     = req.op1 + req.op2 + XLEN'(req.cin);
  assign res_xor = req.op1 ^ req.op2;
  assign res_or  = req.op1 | req.op2;
  assign res_and = req.op1 & req.op2;

  assign o_res = ({XLEN{req.sel_add}} & sum)
               | ({XLEN{req.sel_xor}} & res_xor)
               | ({XLEN{req.sel_or}}  & res_or)
               | ({XLEN{req.sel_and}} & res_and);

  ////////////////////////////////////////
  // Compare flags from rs1 - rs2
  ////////////////////////////////////////
  // Signed overflow of the adder
  assign ovf = (req.op1[XLEN-1] == req.op2[XLEN-1])
             & (sum[XLEN-1] != req.op1[XLEN-1]);

  assign flag_eq = (sum == '0);
  assign flag_lt = sum[XLEN-1] ^ ovf;     // Sign corrected by overflow
  assign flag_gt = ~flag_lt & ~flag_eq;

  assign o_cmp_res = (i_cmp_eq & flag_eq)
                   | (i_cmp_ne & ~flag_eq)
                   | (i_cmp_lt & flag_lt)
                   | (i_cmp_gt & flag_gt);

endmodule

// File: hdl/exu_alu_pkg.sv
////////////////////////////////////////
// ALU execute stage shared definitions
// Widths, vector types, decode info,
// datapath request and commit payloads
////////////////////////////////////////

package exu_alu_pkg;

  localparam int XLEN        = 32;
  localparam int RFIDX_WIDTH = 6;   // Top bit picks the quantum-classical file
  localparam int PC_SIZE     = 32;

  typedef logic [XLEN-1:0]        xlen_t;
  typedef logic [RFIDX_WIDTH-1:0] rfidx_t;
  typedef logic [PC_SIZE-1:0]     pc_t;

  // Decode info from dispatch
  typedef struct packed {
    logic grp_bjp;   // 1 for branch-compare group
    logic alu_add;
    logic alu_sub;
    logic alu_xor;
    logic alu_or;
    logic alu_and;
    logic use_imm;   // Second operand from imm
    logic cmp_eq;
    logic cmp_ne;
    logic cmp_lt;
    logic cmp_gt;
    logic bprdt;     // Predicted branch outcome
  } dec_info_t;

  // Request into the shared datapath
  typedef struct packed {
    xlen_t op1;
    xlen_t op2;
    logic  cin;      // Adder carry-in
    logic  sel_add;
    logic  sel_xor;
    logic  sel_or;
    logic  sel_and;
  } alu_req_t;

  // Commit port payload
  typedef struct packed {
    pc_t   pc;
    xlen_t imm;
    logic  bjp;
    logic  prdt;
    logic  rslv;
  } cmt_t;

  // Write-back port payload
  typedef struct packed {
    xlen_t  data;
    rfidx_t rdidx;
  } wbck_t;

endpackage

// File: hdl/exu_alu_rglr.sv
////////////////////////////////////////
// Regular ALU unit
// Datapath request for add, sub, xor,
// or and and
////////////////////////////////////////

`timescale 1ns/1ps

module exu_alu_rglr (
  input  exu_alu_pkg::xlen_t     i_rs1,
  input  exu_alu_pkg::xlen_t     i_rs2,
  input  exu_alu_pkg::xlen_t     i_imm,
  input  exu_alu_pkg::dec_info_t i_info,
  input  exu_alu_pkg::xlen_t     i_res,
  output exu_alu_pkg::alu_req_t  o_req,
  output exu_alu_pkg::xlen_t     o_wdata
);
  import exu_alu_pkg::*;

  xlen_t op2_raw;
  logic  op_any;

  // Immediate or register as second operand
  assign op2_raw = i_info.use_imm ? i_imm : i_rs2;

  assign op_any = i_info.alu_add | i_info.alu_sub | i_info.alu_xor
                | i_info.alu_or  | i_info.alu_and;

  assign o_req.op1 = i_rs1;
  // Subtract as add of inverted operand plus one
  assign o_req.op2 = i_info.alu_sub ? ~op2_raw : op2_raw;
  assign o_req.cin = i_info.alu_sub;

  assign o_req.sel_add = i_info.alu_add | i_info.alu_sub;
  assign o_req.sel_xor = i_info.alu_xor;
  assign o_req.sel_or  = i_info.alu_or;
  assign o_req.sel_and = i_info.alu_and;

  // No operation selected gives zero data
  assign o_wdata = op_any ? i_res : '0;

endmodule

// File: verif/exu_alu_properties.sv
////////////////////////////////////////
// Commit stage assertions
// Coupled transfers, held payloads and
// quiet outputs during reset
////////////////////////////////////////

`timescale 1ns/1ps

module exu_alu_properties (
  input logic               clk,
  input logic               i_rst,
  input logic               i_vld,
  input logic               i_drain,
  input logic               i_need_cwbck,
  input logic               i_need_qcwbck,
  input logic               i_cmt_ready,
  input logic               i_cwbck_ready,
  input logic               i_qcwbck_ready,
  input logic               i_cmt_valid,
  input logic               i_cwbck_valid,
  input logic               i_qcwbck_valid,
  input exu_alu_pkg::cmt_t  i_cmt,
  input exu_alu_pkg::wbck_t i_cwbck,
  input exu_alu_pkg::wbck_t i_qcwbck
);

  // Commit and the needed write-back move in the same cycle
  a_cwbck_coupled: assert property (@(posedge clk) disable iff (i_rst)
    i_need_cwbck |-> ((i_cmt_valid && i_cmt_ready) == (i_cwbck_valid && i_cwbck_ready)))
    else $error("Commit and classical write-back transferred in different cycles");

  a_qcwbck_coupled: assert property (@(posedge clk) disable iff (i_rst)
    i_need_qcwbck |-> ((i_cmt_valid && i_cmt_ready) == (i_qcwbck_valid && i_qcwbck_ready)))
    else $error("Commit and quantum-classical write-back transferred in different cycles");

  // Held entry keeps its payload
  a_held_stable: assert property (@(posedge clk) disable iff (i_rst)
    (i_vld && !i_drain) |=> ($stable(i_cmt) && $stable(i_cwbck) && $stable(i_qcwbck)))
    else $error("Payload changed while the entry was held");

  a_reset_idle: assert property (@(posedge clk)
    i_rst |=> !(i_cmt_valid || i_cwbck_valid || i_qcwbck_valid))
    else $error("Output valid high during reset");

endmodule

bind exu_alu_commit exu_alu_properties u_props (
  .clk            (clk),
  .i_rst          (i_rst),
  .i_vld          (vld_q),
  .i_drain        (drain),
  .i_need_cwbck   (need_cwbck),
  .i_need_qcwbck  (need_qcwbck),
  .i_cmt_ready    (i_cmt_ready),
  .i_cwbck_ready  (i_cwbck_ready),
  .i_qcwbck_ready (i_qcwbck_ready),
  .i_cmt_valid    (o_cmt_valid),
  .i_cwbck_valid  (o_cwbck_valid),
  .i_qcwbck_valid (o_qcwbck_valid),
  .i_cmt          (o_cmt),
  .i_cwbck        (o_cwbck),
  .i_qcwbck       (o_qcwbck)
);

// File: verif/exu_alu_tb.sv
////////////////////////////////////////
// ALU execute stage testbench
// Stimulus table, random ready levels,
// in-order drain monitor and timeout
////////////////////////////////////////

`timescale 1ns/1ps

module exu_alu_tb;
  import exu_alu_pkg::*;

  localparam int          NUM_ROWS = 20;
  localparam int          TIMEOUT  = NUM_ROWS * 20;
  localparam logic [31:0] SEED     = 32'hccff_2ca1;

  // Bit 3 marks the branch-compare group
  localparam logic [3:0] OP_ADD = 4'h0;
  localparam logic [3:0] OP_SUB = 4'h1;
  localparam logic [3:0] OP_XOR = 4'h2;
  localparam logic [3:0] OP_OR  = 4'h3;
  localparam logic [3:0] OP_AND = 4'h4;
  localparam logic [3:0] CMP_EQ = 4'h8;
  localparam logic [3:0] CMP_NE = 4'h9;
  localparam logic [3:0] CMP_LT = 4'ha;
  localparam logic [3:0] CMP_GT = 4'hb;

  typedef struct packed {
    logic [3:0] op;
    xlen_t      rs1;
    xlen_t      rs2;
    xlen_t      imm;
    logic [2:0] flags;      // {use_imm, rdwen, prdt}
    rfidx_t     rdidx;
    pc_t        pc;
    xlen_t      exp_data;
    logic       exp_rslv;
  } row_t;

  logic      clk = 1'b0;
  logic      i_rst;
  logic      i_valid;
  logic      o_ready;
  xlen_t     i_rs1;
  xlen_t     i_rs2;
  xlen_t     i_imm;
  dec_info_t i_info;
  pc_t       i_pc;
  rfidx_t    i_rdidx;
  logic      i_rdwen;
  logic      o_cmt_valid;
  logic      i_cmt_ready = 1'b0;
  cmt_t      o_cmt;
  logic      o_cwbck_valid;
  logic      i_cwbck_ready = 1'b0;
  wbck_t     o_cwbck;
  logic      o_qcwbck_valid;
  logic      i_qcwbck_ready = 1'b0;
  wbck_t     o_qcwbck;

  row_t      tbl [NUM_ROWS];
  int        drained = 0;
  int        checks  = 0;
  int        errors  = 0;
  int        cycles  = 0;
  logic      rst_d   = 1'b1;

  exu_alu i_dut (.*);

  always #2 clk = ~clk;

  function automatic row_t entry(logic [3:0] op, xlen_t rs1, xlen_t rs2, xlen_t imm,
                                 logic [2:0] flags, rfidx_t rdidx, pc_t pc,
                                 xlen_t exp_data, logic exp_rslv);
    return {op, rs1, rs2, imm, flags, rdidx, pc, exp_data, exp_rslv};
  endfunction

  // One-hot decode fields from the row's operation code
  function automatic dec_info_t decode_info(input row_t r);
    dec_info_t info;
    info         = '0;
    info.grp_bjp = r.op[3];
    info.use_imm = r.flags[2];
    info.bprdt   = r.flags[0];
    info.alu_add = (r.op == OP_ADD);
    info.alu_sub = (r.op == OP_SUB);
    info.alu_xor = (r.op == OP_XOR);
    info.alu_or  = (r.op == OP_OR);
    info.alu_and = (r.op == OP_AND);
    info.cmp_eq  = (r.op == CMP_EQ);
    info.cmp_ne  = (r.op == CMP_NE);
    info.cmp_lt  = (r.op == CMP_LT);
    info.cmp_gt  = (r.op == CMP_GT);
    return info;
  endfunction

  task automatic drive_row(input row_t r);
    i_valid = 1'b1;
    i_rs1   = r.rs1;
    i_rs2   = r.rs2;
    i_imm   = r.imm;
    i_info  = decode_info(r);
    i_pc    = r.pc;
    i_rdidx = r.rdidx;
    i_rdwen = r.flags[1];
  endtask

  task automatic finish_run(input logic timed_out);
    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // Ready levels high about three quarters of the time
  always @(negedge clk) begin
    i_cmt_ready    = ($urandom % 4) != 0;
    i_cwbck_ready  = ($urandom % 4) != 0;
    i_qcwbck_ready = ($urandom % 4) != 0;
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin
    logic accepted;
    void'($urandom(SEED));
    i_rst          = 1'b1;
    i_valid        = 1'b0;
    i_rs1          = '0;
    i_rs2          = '0;
    i_imm          = '0;
    i_info         = '0;
    i_pc           = '0;
    i_rdidx        = '0;
    i_rdwen        = 1'b0;
    // op, rs1, rs2, imm, flags, rdidx, pc, expected data, expected resolve
    tbl[0]  = entry(OP_ADD, 'h1234, 'h111, 'habc, 3'b010, 6'h05, 'h1000, 'h1345, 1'b0);
    tbl[1]  = entry(OP_ADD, 'hfffffff0, 'hdeadbeef, 'h20, 3'b110, 6'h06, 'h1004, 'h10, 1'b0);
    tbl[2]  = entry(OP_SUB, 'h100, 'h1, 'h7ff, 3'b010, 6'h07, 'h1008, 'hff, 1'b0);
    tbl[3]  = entry(OP_SUB, 'h5, 'h3, 'ha, 3'b110, 6'h08, 'h100c, 'hfffffffb, 1'b0);
    tbl[4]  = entry(OP_XOR, 'hf0f0f0f0, 'hff00ff00, 'h0, 3'b010, 6'h09, 'h1010, 'h0ff00ff0, 1'b0);
    tbl[5]  = entry(OP_XOR, 'h12345678, 'h0, 'hffffffff, 3'b110, 6'h0a, 'h1014, 'hedcba987, 1'b0);
    tbl[6]  = entry(OP_OR, 'hf0, 'hf0f, 'h1, 3'b010, 6'h0b, 'h1018, 'hfff, 1'b0);
    tbl[7]  = entry(OP_OR, 'h80000000, 'h2, 'h1, 3'b110, 6'h0c, 'h101c, 'h80000001, 1'b0);
    tbl[8]  = entry(OP_AND, 'ha5a5a5a5, 'h0f0f0f0f, 'h3, 3'b010, 6'h0d, 'h1020, 'h05050505, 1'b0);
    tbl[9]  = entry(OP_AND, 'h12345678, 'h0, 'hffff, 3'b110, 6'h21, 'h1024, 'h5678, 1'b0);
    tbl[10] = entry(OP_SUB, 'h10, 'h20, 'h0, 3'b010, 6'h3f, 'h1028, 'hfffffff0, 1'b0);
    tbl[11] = entry(CMP_EQ, 'h55, 'h55, 'h40, 3'b011, 6'h01, 'h2000, 'h0, 1'b1);
    tbl[12] = entry(CMP_EQ, 'h55, 'h56, 'h44, 3'b011, 6'h21, 'h2004, 'h0, 1'b0);
    tbl[13] = entry(CMP_NE, 'h80000000, 'h0, 'h48, 3'b010, 6'h02, 'h2008, 'h0, 1'b1);
    tbl[14] = entry(CMP_NE, 'hffffffff, 'hffffffff, 'h4c, 3'b001, 6'h03, 'h200c, 'h0, 1'b0);
    tbl[15] = entry(CMP_LT, 'hfffffffe, 'h3, 'h50, 3'b010, 6'h04, 'h2010, 'h0, 1'b1);
    tbl[16] = entry(CMP_LT, 'h7fffffff, 'h80000000, 'h54, 3'b011, 6'h05, 'h2014, 'h0, 1'b0);
    tbl[17] = entry(CMP_GT, 'h1, 'hffffffff, 'h58, 3'b011, 6'h06, 'h2018, 'h0, 1'b1);
    tbl[18] = entry(CMP_GT, 'h80000000, 'h7fffffff, 'h5c, 3'b010, 6'h07, 'h201c, 'h0, 1'b0);
    tbl[19] = entry(OP_ADD, 'h7, 'h9, 'h0, 3'b000, 6'h0e, 'h102c, 'h10, 1'b0);

    repeat (3) @(posedge clk);
    @(negedge clk);
    i_rst = 1'b0;

    for (int i = 0; i < NUM_ROWS; i++) begin
      @(negedge clk);
      drive_row(tbl[i]);
      accepted = 1'b0;
      while (!accepted) begin
        @(posedge clk);
        accepted = o_ready;   // Valid is high, so ready means taken
      end
    end
    @(negedge clk);
    i_valid = 1'b0;

    while (drained < NUM_ROWS) begin
      @(negedge clk);
    end
    repeat (4) @(posedge clk);  // Catch any extra commit
    finish_run(1'b0);
  end

  ////////////////////////////////////////
  // Drain monitor
  ////////////////////////////////////////
  always @(posedge clk) begin : monitor
    row_t  r;
    cmt_t  exp_cmt;
    wbck_t exp_wbck;
    wbck_t got_wbck;
    logic  cmt_xfer;
    logic  c_xfer;
    logic  qc_xfer;
    logic  need_wb;
    logic  qc;
    cmt_xfer = o_cmt_valid & i_cmt_ready;
    c_xfer   = o_cwbck_valid & i_cwbck_ready;
    qc_xfer  = o_qcwbck_valid & i_qcwbck_ready;
    if (rst_d && !i_rst) begin
      checks++;
      if ({o_cmt_valid, o_cwbck_valid, o_qcwbck_valid, o_ready} !== 4'b0001) begin
        $display("CHECK FAILED after reset {o_cmt_valid,o_cwbck_valid,o_qcwbck_valid,o_ready}: %s",
                 $sformatf("got %h expected %h",
                           {o_cmt_valid, o_cwbck_valid, o_qcwbck_valid, o_ready}, 4'b0001));
        errors++;
      end
    end
    if (!i_rst && (c_xfer || qc_xfer) && !cmt_xfer) begin
      $display("ERROR: write-back transferred without a commit in cycle %0d", cycles);
      errors++;
    end
    if (!i_rst && cmt_xfer) begin
      if (drained >= NUM_ROWS) begin
        $display("ERROR: commit seen after every row had drained");
        errors++;
      end else begin
        r            = tbl[drained];
        exp_cmt.pc   = r.pc;
        exp_cmt.imm  = r.imm;
        exp_cmt.bjp  = r.op[3];
        exp_cmt.prdt = r.op[3] & r.flags[0];
        exp_cmt.rslv = r.exp_rslv;
        need_wb      = ~r.op[3] & r.flags[1];   // Only ALU rows write back
        qc           = r.rdidx[RFIDX_WIDTH-1];
        checks += 3;
        if (o_cmt !== exp_cmt) begin
          $display("CHECK FAILED row %0d o_cmt: got %h expected %h", drained, o_cmt, exp_cmt);
          errors++;
        end
        if (c_xfer !== (need_wb & ~qc)) begin
          $display("CHECK FAILED row %0d cwbck transfer: got %h expected %h",
                   drained, c_xfer, need_wb & ~qc);
          errors++;
        end
        if (qc_xfer !== (need_wb & qc)) begin
          $display("CHECK FAILED row %0d qcwbck transfer: got %h expected %h",
                   drained, qc_xfer, need_wb & qc);
          errors++;
        end
        if (need_wb) begin
          exp_wbck.data  = r.exp_data;
          exp_wbck.rdidx = r.rdidx;
          got_wbck       = qc ? o_qcwbck : o_cwbck;
          checks++;
          if (got_wbck !== exp_wbck) begin
            $display("CHECK FAILED row %0d %s: got %h expected %h", drained,
                     qc ? "o_qcwbck" : "o_cwbck", got_wbck, exp_wbck);
            errors++;
          end
        end
        drained++;
      end
    end
    rst_d = i_rst;
  end

  // Cycle limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: %0d of %0d rows drained after %0d cycles", drained, NUM_ROWS, cycles);
      finish_run(1'b1);
    end
  end

endmodule

// File: verilog.f
hdl/exu_alu_pkg.sv
hdl/exu_alu_rglr.sv
hdl/exu_alu_bjp.sv
hdl/exu_alu_dpath.sv
hdl/exu_alu_commit.sv
hdl/exu_alu.sv
verif/exu_alu_properties.sv
verif/exu_alu_tb.sv
